//--- build.f
verilog/zx_bus_pkg.sv
verilog/zx_mem_map_pkg.sv
verilog/mem_port_if.sv
verilog/word_mem.sv
verilog/mem_arbiter.sv
verilog/cpu_pager.sv
verilog/gs_mem_port.sv
verilog/dl_loader.sv
verilog/zx_mem_top.sv
test/tb_zx_mem.sv

//--- run.sh
#!/bin/sh
# Build the memory system testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_zx_mem -o tb_zx_mem -f build.f

out=$(./obj_dir/tb_zx_mem)
printf '%s\n' "$out"

# Exit status follows the pass line
printf '%s\n' "$out" | grep -q '^TEST PASS$'

//--- test/tb_zx_mem.sv
// Testbench for the Spectrum memory system, directed and random traffic against a byte model
`timescale 1ns/1ps

module tb_zx_mem;

	localparam int GS_SIZE_W = 16;
	localparam logic [17:0] GS_LIMIT = 18'(1) << GS_SIZE_W;
	localparam int TIMEOUT = 50; // Cycles allowed per wait

	// Round robin over three ports lets a waiting request lose at most twice
	localparam int GRANT_WAIT = 2;
	localparam int GS_WAIT = GRANT_WAIT + zx_mem_map_pkg::READ_LATENCY; // Own read in flight first

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        cpu_valid, cpu_ready, cpu_we, cpu_io, cpu_rvalid;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata, cpu_rdata;
	logic        gs_valid, gs_ready, gs_we, gs_rvalid;
	logic [17:0] gs_addr;
	logic [7:0]  gs_wdata, gs_rdata;
	logic        dl_valid, dl_ready, dl_region;
	logic [16:0] dl_addr;
	logic [7:0]  dl_data;

	// ============================================================
	// Reference model
	// ============================================================
	logic [7:0] model_mem [2**19];
	bit         known [2**19];   // Byte has been written
	logic [7:0] page;            // 7FFD as the model sees it
	logic [7:0] cpu_q [$];
	logic [7:0] gs_q [$];

	// Mid-cycle samples, checked on the following rising edge
	logic       cpu_acc, gs_acc, dl_acc;
	logic       cpu_seen, cpu_have, gs_seen, gs_have;
	logic [7:0] cpu_got, cpu_want, gs_got, gs_want;
	int         cpu_wait, gs_wait, dl_wait; // Cycles a request has waited so far

	string test_name = "reset";
	int    test_err, tests, failed, total_err;

	zx_mem_top #(.GS_SIZE_W(GS_SIZE_W)) u_zx_mem_top (.*);

	always #50 clk_sys = ~clk_sys;

	// Z80 address to shared memory byte address
	function automatic zx_bus_pkg::mem_addr_t cpu_map(input logic [15:0] a);
		case (a[15:14])
			2'd0: return zx_mem_map_pkg::ROM_BASE + 19'({page[4], a[13:0]});
			2'd1: return zx_mem_map_pkg::RAM_BASE + 19'({3'd5, a[13:0]});
			2'd2: return zx_mem_map_pkg::RAM_BASE + 19'({3'd2, a[13:0]});
			default: return zx_mem_map_pkg::RAM_BASE + 19'({page[2:0], a[13:0]});
		endcase
	endfunction

	always @(negedge clk_sys) begin
		zx_bus_pkg::mem_addr_t a;
		if (reset) begin
			page     = 8'h00;
			cpu_seen = 1'b0;
			gs_seen  = 1'b0;
			cpu_acc  = 1'b0;
			gs_acc   = 1'b0;
			dl_acc   = 1'b0;
			cpu_wait = 0;
			gs_wait  = 0;
			dl_wait  = 0;
		end else begin
			// Responses first, a read accepted now answers in a later cycle
			cpu_seen = cpu_rvalid;
			cpu_got  = cpu_rdata;
			cpu_have = cpu_q.size() > 0;
			if (cpu_seen && cpu_have)
				cpu_want = cpu_q.pop_front();
			gs_seen = gs_rvalid;
			gs_got  = gs_rdata;
			gs_have = gs_q.size() > 0;
			if (gs_seen && gs_have)
				gs_want = gs_q.pop_front();

			cpu_acc = cpu_valid && cpu_ready;
			gs_acc  = gs_valid && gs_ready;
			dl_acc  = dl_valid && dl_ready;

			cpu_wait = (cpu_valid && !cpu_ready) ? cpu_wait + 1 : 0;
			gs_wait  = (gs_valid && !gs_ready) ? gs_wait + 1 : 0;
			dl_wait  = (dl_valid && !dl_ready) ? dl_wait + 1 : 0;

			if (cpu_acc && cpu_io) begin
				if (cpu_we && !cpu_addr[15] && !cpu_addr[1] && !page[5]) // Bit 5 locks
					page = cpu_wdata;
			end else if (cpu_acc) begin
				a = cpu_map(cpu_addr);
				if (!cpu_we) begin
					cpu_q.push_back(model_mem[a]);
				end else if (cpu_addr[15:14] != 2'b00) begin // ROM writes vanish
					model_mem[a] = cpu_wdata;
					known[a]     = 1'b1;
				end
			end

			if (gs_acc) begin
				a = zx_mem_map_pkg::GS_BASE + 19'(gs_addr);
				if (gs_addr >= GS_LIMIT) begin
					if (!gs_we)
						gs_q.push_back(8'hFF);
				end else if (gs_we) begin
					model_mem[a] = gs_wdata;
					known[a]     = 1'b1;
				end else begin
					gs_q.push_back(model_mem[a]);
				end
			end

			if (dl_acc) begin
				a = (dl_region ? zx_mem_map_pkg::RAM_BASE : zx_mem_map_pkg::ROM_BASE)
					+ 19'(dl_addr);
				model_mem[a] = dl_data;
				known[a]     = 1'b1;
			end
		end
	end

	// ============================================================
	// Checks
	// ============================================================
	a_cpu_expected: assert property (@(posedge clk_sys) disable iff (reset) cpu_seen |-> cpu_have)
		else begin
			$display("%s: CPU read data arrived with no read outstanding", test_name);
			test_err++;
		end
	a_cpu_data: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_seen && cpu_have) |-> cpu_got == cpu_want)
		else begin
			$display("** Error %s: CPU read expected %02h actual %02h", test_name, cpu_want, cpu_got);
			test_err++;
		end
	a_gs_expected: assert property (@(posedge clk_sys) disable iff (reset) gs_seen |-> gs_have)
		else begin
			$display("%s: GS read data arrived with no read outstanding", test_name);
			test_err++;
		end
	a_gs_data: assert property (@(posedge clk_sys) disable iff (reset)
		(gs_seen && gs_have) |-> gs_got == gs_want)
		else begin
			$display("** Error %s: GS read expected %02h actual %02h", test_name, gs_want, gs_got);
			test_err++;
		end

	a_cpu_grant: assert property (@(posedge clk_sys) disable iff (reset) cpu_wait <= GRANT_WAIT)
		else begin
			$display("%s: CPU request waited too long for a grant", test_name);
			test_err++;
		end
	a_gs_grant: assert property (@(posedge clk_sys) disable iff (reset) gs_wait <= GS_WAIT)
		else begin
			$display("%s: GS request waited too long for a grant", test_name);
			test_err++;
		end
	a_dl_grant: assert property (@(posedge clk_sys) disable iff (reset) dl_wait <= GRANT_WAIT)
		else begin
			$display("%s: download byte waited too long for a grant", test_name);
			test_err++;
		end

	// ============================================================
	// Stimulus tasks
	// ============================================================
	task automatic wait_accept(input int port);
		int   t;
		logic rdy;
		t = 0;
		do begin
			@(negedge clk_sys);
			rdy = (port == 0) ? cpu_ready : (port == 1) ? gs_ready : dl_ready;
			t++;
		end while (!rdy && t < TIMEOUT);
		if (!rdy) begin
			$display("%s: request on port %0d was never accepted", test_name, port);
			test_err++;
		end
		@(posedge clk_sys); // Transfer edge
	endtask

	task automatic cpu_op(input logic [15:0] a, input logic we, input logic io,
		input logic [7:0] d);
		@(posedge clk_sys);
		cpu_valid <= 1'b1;
		cpu_addr  <= a;
		cpu_we    <= we;
		cpu_io    <= io;
		cpu_wdata <= d;
		wait_accept(0);
		cpu_valid <= 1'b0;
	endtask

	task automatic gs_op(input logic [17:0] a, input logic we, input logic [7:0] d);
		@(posedge clk_sys);
		gs_valid <= 1'b1;
		gs_addr  <= a;
		gs_we    <= we;
		gs_wdata <= d;
		wait_accept(1);
		gs_valid <= 1'b0;
	endtask

	task automatic dl_op(input logic [16:0] a, input logic region, input logic [7:0] d);
		@(posedge clk_sys);
		dl_valid  <= 1'b1;
		dl_addr   <= a;
		dl_region <= region;
		dl_data   <= d;
		wait_accept(2);
		dl_valid <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err  = 0;
	endtask

	task automatic wait_reads();
		int t;
		t = 0;
		while ((cpu_q.size() > 0 || gs_q.size() > 0) && t < TIMEOUT) begin
			@(posedge clk_sys);
			t++;
		end
		if (cpu_q.size() > 0 || gs_q.size() > 0) begin
			$display("%s: read responses are still missing", test_name);
			test_err++;
		end
	endtask

	task automatic end_test();
		wait_reads();
		repeat (2) @(posedge clk_sys); // Last checks fire
		tests++;
		total_err += test_err;
		if (test_err == 0) begin
			$display("test %s ok", test_name);
		end else begin
			failed++;
			$display("test %s failed with %0d errors", test_name, test_err);
		end
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		int          i;
		int          t;
		logic [15:0] ca;
		logic [17:0] ga;
		void'($urandom(32'h9b90_5a03));
		reset     = 1'b1;
		cpu_valid = 1'b0;
		cpu_addr  = 16'h0000;
		cpu_we    = 1'b0;
		cpu_io    = 1'b0;
		cpu_wdata = 8'h00;
		gs_valid  = 1'b0;
		gs_addr   = 18'h00000;
		gs_we     = 1'b0;
		gs_wdata  = 8'h00;
		dl_valid  = 1'b0;
		dl_addr   = 17'h00000;
		dl_region = 1'b0;
		dl_data   = 8'h00;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;

		start_test("rom_load");
		for (i = 0; i < 256; i++)
			dl_op(17'(i), 1'b0, 8'($urandom));
		for (i = 0; i < 256; i++)
			cpu_op(16'(i), 1'b0, 1'b0, 8'h00);
		cpu_op(16'h0010, 1'b1, 1'b0, 8'hEE);
		cpu_op(16'h0010, 1'b0, 1'b0, 8'h00);
		end_test();

		start_test("banking");
		for (i = 0; i < 8; i++) begin
			cpu_op(16'h7FFD, 1'b1, 1'b1, 8'(i));
			cpu_op(16'hC000, 1'b1, 1'b0, 8'(8'h40 + i));
		end
		for (i = 0; i < 8; i++) begin
			cpu_op(16'h7FFD, 1'b1, 1'b1, 8'(i));
			cpu_op(16'hC000, 1'b0, 1'b0, 8'h00);
		end
		cpu_op(16'h4000, 1'b1, 1'b0, 8'hA5);
		cpu_op(16'h8000, 1'b1, 1'b0, 8'h5A);
		cpu_op(16'h7FFD, 1'b1, 1'b1, 8'h05);
		cpu_op(16'hC000, 1'b0, 1'b0, 8'h00);
		cpu_op(16'h7FFD, 1'b1, 1'b1, 8'h02);
		cpu_op(16'hC000, 1'b0, 1'b0, 8'h00);
		end_test();

		start_test("lock");
		cpu_op(16'h7FFD, 1'b1, 1'b1, 8'h23); // Bank 3 and lock
		cpu_op(16'h7FFD, 1'b1, 1'b1, 8'h06);
		cpu_op(16'hC000, 1'b0, 1'b0, 8'h00);
		wait_reads();
		apply_reset();
		cpu_op(16'hC000, 1'b0, 1'b0, 8'h00); // Back at bank 0
		end_test();

		start_test("gs_window");
		gs_op(18'h00123, 1'b1, 8'h77);
		gs_op(18'h00123, 1'b0, 8'h00);
		gs_op(18'h10000, 1'b0, 8'h00);
		gs_op(18'h2ABCD, 1'b0, 8'h00);
		gs_op(18'h00200, 1'b1, 8'h3C);
		gs_op(18'h00200, 1'b0, 8'h00);
		gs_op(18'h00200, 1'b0, 8'h00); // Served from the held copy
		gs_op(18'h00200, 1'b1, 8'hC3);
		gs_op(18'h00200, 1'b0, 8'h00);
		end_test();

		// CPU in bank 2, GS in its window, loader in bank 7, so the regions never overlap
		start_test("contention");
		cpu_io <= 1'b0;
		dl_region <= 1'b1;
		for (i = 0; i < 300; i++) begin
			@(posedge clk_sys);
			if (!cpu_valid || cpu_acc) begin
				ca = 16'h8000 | 16'($urandom % 256);
				cpu_valid <= ($urandom % 4 != 0);
				cpu_addr  <= ca;
				cpu_we    <= 1'($urandom) || !known[cpu_map(ca)];
				cpu_wdata <= 8'($urandom);
			end
			if (!gs_valid || gs_acc) begin
				ga = ($urandom % 8 == 0) ? GS_LIMIT + 18'($urandom % 32'h30000)
					: 18'($urandom % 512);
				gs_valid <= ($urandom % 4 != 0);
				gs_addr  <= ga;
				gs_we    <= 1'($urandom)
					|| (ga < GS_LIMIT && !known[zx_mem_map_pkg::GS_BASE + 19'(ga)]);
				gs_wdata <= 8'($urandom);
			end
			if (!dl_valid || dl_acc) begin
				dl_valid <= 1'($urandom);
				dl_addr  <= 17'h1C000 + 17'($urandom % 256);
				dl_data  <= 8'($urandom);
			end
		end
		// Let requests still waiting finish their handshake
		t = 0;
		while ((cpu_valid || gs_valid || dl_valid) && t < TIMEOUT) begin
			@(posedge clk_sys);
			if (cpu_acc)
				cpu_valid <= 1'b0;
			if (gs_acc)
				gs_valid <= 1'b0;
			if (dl_acc)
				dl_valid <= 1'b0;
			t++;
		end
		if (cpu_valid || gs_valid || dl_valid) begin
			$display("%s: pending requests were never accepted", test_name);
			test_err++;
		end
		end_test();

		$display("tests run %0d, failed %0d, errors %0d", tests, failed, total_err);
		if (failed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- verilog/zx_mem_top.sv
// Spectrum memory system top: CPU pager, GS port and loader sharing one word memory
`timescale 1ns/1ps

module zx_mem_top #(
	parameter int GS_SIZE_W = 16
) (
	input  logic        clk_sys,
	input  logic        reset,

	// CPU side
	input  logic        cpu_valid,
	output logic        cpu_ready,
	input  logic [15:0] cpu_addr,
	input  logic        cpu_we,
	input  logic        cpu_io,
	input  logic [7:0]  cpu_wdata,
	output logic        cpu_rvalid,
	output logic [7:0]  cpu_rdata,

	// General Sound side
	input  logic        gs_valid,
	output logic        gs_ready,
	input  logic [17:0] gs_addr,
	input  logic        gs_we,
	input  logic [7:0]  gs_wdata,
	output logic        gs_rvalid,
	output logic [7:0]  gs_rdata,

	// Host download
	input  logic        dl_valid,
	output logic        dl_ready,
	input  logic [16:0] dl_addr,
	input  logic        dl_region,
	input  logic [7:0]  dl_data
);

	localparam int MEM_AW = $bits(zx_bus_pkg::mem_addr_t) - 1; // Word address

	logic              mem_en, mem_we;
	logic [MEM_AW-1:0] mem_waddr;
	logic [1:0]        mem_be;
	logic [15:0]       mem_wdata, mem_rdata;

	mem_port_if cpu_if ();
	mem_port_if gs_if ();
	mem_port_if dl_if ();

	cpu_pager u_cpu_pager (
		.clk_sys, .reset,
		.cpu_valid, .cpu_we, .cpu_io, .cpu_addr, .cpu_wdata,
		.cpu_ready, .cpu_rvalid, .cpu_rdata,
		.mem(cpu_if)
	);

	gs_mem_port #(.GS_SIZE_W(GS_SIZE_W)) u_gs_mem_port (
		.clk_sys, .reset,
		.gs_valid, .gs_we, .gs_addr, .gs_wdata,
		.gs_ready, .gs_rvalid, .gs_rdata,
		.mem(gs_if)
	);

	dl_loader u_dl_loader (
		.clk_sys, .reset,
		.dl_valid, .dl_region, .dl_addr, .dl_data, .dl_ready,
		.mem(dl_if)
	);

	mem_arbiter #(.MEM_AW(MEM_AW)) u_mem_arbiter (
		.clk_sys, .reset,
		.cpu_port(cpu_if), .gs_port(gs_if), .dl_port(dl_if),
		.mem_en, .mem_we, .mem_waddr, .mem_be, .mem_wdata, .mem_rdata
	);

	word_mem #(.MEM_AW(MEM_AW)) u_word_mem (
		.clk_sys,
		.mem_en, .mem_we, .mem_waddr, .mem_be, .mem_wdata, .mem_rdata
	);

endmodule

//--- verilog/dl_loader.sv
// Host download writer, one registered write stage into the ROM or RAM region
`timescale 1ns/1ps

module dl_loader (
	input  logic        clk_sys,
	input  logic        reset,

	input  logic        dl_valid,
	input  logic        dl_region,  // 0 ROM, 1 RAM
	input  logic [16:0] dl_addr,
	input  logic [7:0]  dl_data,
	output logic        dl_ready,

	mem_port_if.requester mem
);

	logic                  stage_v;
	zx_bus_pkg::mem_addr_t stage_addr;
	logic [7:0]            stage_data;

	// Stage frees up on the grant of its byte
	assign dl_ready = !stage_v || mem.req_ready;

	always_ff @(posedge clk_sys) begin
		if (reset)
			stage_v <= 1'b0;
		else if (dl_valid && dl_ready)
			stage_v <= 1'b1;
		else if (mem.req_ready)
			stage_v <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (dl_valid && dl_ready) begin
			stage_addr <= (dl_region ? zx_mem_map_pkg::RAM_BASE : zx_mem_map_pkg::ROM_BASE)
				+ zx_bus_pkg::mem_addr_t'(dl_addr);
			stage_data <= dl_data;
		end
	end

	assign mem.req_valid = stage_v;
	assign mem.req_addr  = stage_addr;
	assign mem.req_we    = 1'b1; // Write only
	assign mem.req_wdata = stage_data;

	// Arbiter must never route read data to this write-only port
	a_no_rsp: assert property (@(posedge clk_sys) disable iff (reset) !mem.rsp_valid);

endmodule

//--- verilog/gs_mem_port.sv
// General Sound memory port: size mask, FF above fitted memory, reuse of the last read byte
`timescale 1ns/1ps

module gs_mem_port #(
	parameter int GS_SIZE_W = 16
) (
	input  logic        clk_sys,
	input  logic        reset,

	input  logic        gs_valid,
	input  logic        gs_we,
	input  logic [17:0] gs_addr,
	input  logic [7:0]  gs_wdata,
	output logic        gs_ready,
	output logic        gs_rvalid,
	output logic [7:0]  gs_rdata,

	mem_port_if.requester mem
);

	logic        in_range, is_hit, local_op, accept, pend;
	logic        hold_valid;
	logic [17:0] hold_addr;
	logic [7:0]  hold_data;
	logic        local_rvalid;
	logic [7:0]  local_rdata;

	assign in_range = (gs_addr >> GS_SIZE_W) == '0;
	assign is_hit   = hold_valid && (gs_addr == hold_addr);
	assign local_op = !in_range || (!gs_we && is_hit);  // Answered without memory

	// One pass-through read at a time keeps responses in order
	assign gs_ready = !pend && (local_op || mem.req_ready);
	assign accept   = gs_valid && gs_ready;

	assign mem.req_valid = gs_valid && !pend && !local_op;
	assign mem.req_addr  = zx_mem_map_pkg::GS_BASE + zx_bus_pkg::mem_addr_t'(gs_addr);
	assign mem.req_we    = gs_we;
	assign mem.req_wdata = gs_wdata;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pend         <= 1'b0;
			hold_valid   <= 1'b0;
			local_rvalid <= 1'b0;
		end else begin
			local_rvalid <= accept && !gs_we && local_op;
			if (accept && !gs_we && !local_op) begin
				pend       <= 1'b1;
				hold_valid <= 1'b0; // Copy refills from the response
			end else if (mem.rsp_valid) begin
				pend       <= 1'b0;
				hold_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept && !gs_we && !local_op)
			hold_addr <= gs_addr;
		if (accept && !gs_we)
			local_rdata <= in_range ? hold_data : 8'hFF;
		if (mem.rsp_valid)
			hold_data <= mem.rsp_data;
		else if (accept && gs_we && is_hit)
			hold_data <= gs_wdata; // Write through keeps the copy current
	end

	assign gs_rvalid = local_rvalid || mem.rsp_valid;
	assign gs_rdata  = mem.rsp_valid ? mem.rsp_data : local_rdata;

	// Reuse needs a filled copy and answers with it a cycle later
	a_hit_valid: assert property (@(posedge clk_sys) disable iff (reset)
		(accept && !gs_we && is_hit) |-> hold_valid ##1 (gs_rvalid && gs_rdata == $past(hold_data)));

endmodule

//--- verilog/cpu_pager.sv
// Z80 memory pager: 7FFD paging register with lock, segment mapping and ROM write guard
`timescale 1ns/1ps

module cpu_pager (
	input  logic        clk_sys,
	input  logic        reset,

	input  logic        cpu_valid,
	input  logic        cpu_we,
	input  logic        cpu_io,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	output logic        cpu_ready,
	output logic        cpu_rvalid,
	output logic [7:0]  cpu_rdata,

	mem_port_if.requester mem
);

	localparam int OFS_W = zx_mem_map_pkg::BANK_W;
	localparam int ROM_SEL_W = $clog2(zx_mem_map_pkg::ROM_PAGES);

	zx_bus_pkg::page_reg_u page_reg;
	zx_bus_pkg::mem_addr_t seg_base;

	logic [ROM_SEL_W-1:0] rom_page;
	logic                 rom_seg;
	logic                 local_op;
	logic                 page_write;

	// ============================================================
	// Paging register
	// ============================================================
	// Port 7FFD decodes on A15 and A1 low
	assign page_write = cpu_valid && cpu_io && cpu_we && !cpu_addr[15] && !cpu_addr[1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg.raw <= 8'h00; // Bank 0, ROM 0, unlocked
		end else if (page_write && !page_reg.f.lock) begin
			page_reg.raw <= cpu_wdata;
		end
	end

	assign rom_page = page_reg.f.rom_sel;

	// ============================================================
	// Segment mapping
	// ============================================================
	always_comb begin
		case (cpu_addr[15:14])
			2'd0: seg_base = zx_mem_map_pkg::ROM_BASE
				+ zx_bus_pkg::mem_addr_t'(rom_page) * zx_mem_map_pkg::BANK_SIZE;
			2'd1: seg_base = zx_mem_map_pkg::RAM_BASE
				+ zx_bus_pkg::mem_addr_t'(zx_mem_map_pkg::FIXED_BANK_1) * zx_mem_map_pkg::BANK_SIZE;
			2'd2: seg_base = zx_mem_map_pkg::RAM_BASE
				+ zx_bus_pkg::mem_addr_t'(zx_mem_map_pkg::FIXED_BANK_2) * zx_mem_map_pkg::BANK_SIZE;
			default: seg_base = zx_mem_map_pkg::RAM_BASE
				+ zx_bus_pkg::mem_addr_t'(page_reg.f.ram_bank) * zx_mem_map_pkg::BANK_SIZE;
		endcase
	end

	assign rom_seg = (cpu_addr[15:14] == 2'b00);

	// I/O cycles and ROM writes end here, other I/O devices live elsewhere
	assign local_op = cpu_io || (cpu_we && rom_seg);

	assign cpu_ready = local_op || mem.req_ready;

	assign mem.req_valid = cpu_valid && !local_op;
	assign mem.req_addr  = seg_base + zx_bus_pkg::mem_addr_t'(cpu_addr[OFS_W-1:0]);
	assign mem.req_we    = cpu_we;
	assign mem.req_wdata = cpu_wdata;

	assign cpu_rvalid = mem.rsp_valid; // Arbiter keeps read order
	assign cpu_rdata  = mem.rsp_data;

	// Locked paging stays frozen until reset
	a_lock_holds: assert property (@(posedge clk_sys) disable iff (reset)
		page_reg.f.lock |=> $stable(page_reg.raw));

endmodule

//--- verilog/mem_arbiter.sv
// Round-robin memory arbiter for three requesters, in-order read data routing
`timescale 1ns/1ps

module mem_arbiter #(
	parameter int MEM_AW = 18
) (
	input  logic              clk_sys,
	input  logic              reset,

	mem_port_if.arbiter       cpu_port,
	mem_port_if.arbiter       gs_port,
	mem_port_if.arbiter       dl_port,

	output logic              mem_en,
	output logic              mem_we,
	output logic [MEM_AW-1:0] mem_waddr,
	output logic [1:0]        mem_be,
	output logic [15:0]       mem_wdata,
	input  logic [15:0]       mem_rdata
);

	localparam int LAT = zx_mem_map_pkg::READ_LATENCY;

	logic [2:0]                req, grant, r_we;
	zx_bus_pkg::mem_addr_t     r_addr  [3];
	logic [7:0]                r_wdata [3];
	zx_bus_pkg::port_id_t      winner, last_win;
	zx_bus_pkg::mem_addr_t     sel_addr;

	// Read tag pipeline, lines up with the memory read stages
	logic [LAT-1:0]            pipe_v;
	zx_bus_pkg::port_id_t      pipe_id   [LAT];
	logic                      pipe_lane [LAT];
	logic [7:0]                rsp_byte;

	assign req     = {dl_port.req_valid, gs_port.req_valid, cpu_port.req_valid};
	assign r_we    = {dl_port.req_we, gs_port.req_we, cpu_port.req_we};
	assign r_addr  = '{cpu_port.req_addr, gs_port.req_addr, dl_port.req_addr};
	assign r_wdata = '{cpu_port.req_wdata, gs_port.req_wdata, dl_port.req_wdata};

	// ============================================================
	// Round robin, search starts after the last winner
	// ============================================================
	always_comb begin
		int idx;
		grant  = '0;
		winner = last_win;
		for (int k = 1; k <= 3; k++) begin
			idx = (int'(last_win) + k) % 3;
			if (req[idx] && grant == '0) begin
				grant[idx] = 1'b1;
				winner     = zx_bus_pkg::port_id_t'(idx);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			last_win <= zx_bus_pkg::PORT_DL; // CPU goes first
		else if (mem_en)
			last_win <= winner;
	end

	assign cpu_port.req_ready = grant[0];
	assign gs_port.req_ready  = grant[1];
	assign dl_port.req_ready  = grant[2];

	assign sel_addr  = r_addr[winner];
	assign mem_en    = |grant;
	assign mem_we    = r_we[winner];
	assign mem_waddr = sel_addr[MEM_AW:1];
	assign mem_be    = mem_we ? {sel_addr[0], !sel_addr[0]} : 2'b11;
	assign mem_wdata = {2{r_wdata[winner]}}; // Byte on both lanes

	// ============================================================
	// Response routing
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset)
			pipe_v <= '0;
		else
			pipe_v <= {pipe_v[LAT-2:0], mem_en && !mem_we};
	end

	always_ff @(posedge clk_sys) begin
		pipe_id[0]   <= winner;
		pipe_lane[0] <= sel_addr[0];
		for (int i = 1; i < LAT; i++) begin
			pipe_id[i]   <= pipe_id[i-1];
			pipe_lane[i] <= pipe_lane[i-1];
		end
	end

	assign rsp_byte = pipe_lane[LAT-1] ? mem_rdata[15:8] : mem_rdata[7:0];

	assign cpu_port.rsp_valid = pipe_v[LAT-1] && (pipe_id[LAT-1] == zx_bus_pkg::PORT_CPU);
	assign gs_port.rsp_valid  = pipe_v[LAT-1] && (pipe_id[LAT-1] == zx_bus_pkg::PORT_GS);
	assign dl_port.rsp_valid  = pipe_v[LAT-1] && (pipe_id[LAT-1] == zx_bus_pkg::PORT_DL);
	assign cpu_port.rsp_data  = rsp_byte;
	assign gs_port.rsp_data   = rsp_byte;
	assign dl_port.rsp_data   = rsp_byte;

	a_one_grant: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({cpu_port.req_ready, gs_port.req_ready, dl_port.req_ready}));

endmodule

//--- verilog/word_mem.sv
// Word-wide shared memory with byte lane writes and a fixed read pipeline
`timescale 1ns/1ps

module word_mem #(
	parameter int MEM_AW = 18
) (
	input  logic              clk_sys,
	input  logic              mem_en,
	input  logic              mem_we,
	input  logic [MEM_AW-1:0] mem_waddr,
	input  logic [1:0]        mem_be,
	input  logic [15:0]       mem_wdata,
	output logic [15:0]       mem_rdata
);

	localparam int LAT = zx_mem_map_pkg::READ_LATENCY;

	logic [15:0] ram [2**MEM_AW];
	logic [15:0] rd_pipe [LAT];   // Stage 0 is the array read register

	always_ff @(posedge clk_sys) begin
		if (mem_en && mem_we) begin
			if (mem_be[0]) ram[mem_waddr][7:0]  <= mem_wdata[7:0];
			if (mem_be[1]) ram[mem_waddr][15:8] <= mem_wdata[15:8];
		end
		if (mem_en && !mem_we)
			rd_pipe[0] <= ram[mem_waddr];
		for (int i = 1; i < LAT; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	assign mem_rdata = rd_pipe[LAT-1];

endmodule

//--- verilog/mem_port_if.sv
// Link from one memory requester to the shared arbiter, valid/ready request and response pulse
`timescale 1ns/1ps

interface mem_port_if;

	// Request, driven by the requester
	logic                  req_valid;
	zx_bus_pkg::mem_addr_t req_addr;
	logic                  req_we;
	logic [7:0]            req_wdata;

	logic                  req_ready; // Grant from the arbiter

	// Read response, one pulse per accepted read, no back-pressure
	logic                  rsp_valid;
	logic [7:0]            rsp_data;

	modport requester (
		output req_valid, req_addr, req_we, req_wdata,
		input  req_ready, rsp_valid, rsp_data
	);

	modport arbiter (
		input  req_valid, req_addr, req_we, req_wdata,
		output req_ready, rsp_valid, rsp_data
	);

endinterface

//--- verilog/zx_mem_map_pkg.sv
// Shared memory map of the Spectrum memory system: region bases, bank geometry, read latency
package zx_mem_map_pkg;

	// ============================================================
	// Region bases, byte addresses
	// ============================================================
	localparam zx_bus_pkg::mem_addr_t RAM_BASE = 19'h00000; // Eight 16K RAM banks
	localparam zx_bus_pkg::mem_addr_t ROM_BASE = 19'h20000; // ROM pages, download target
	localparam zx_bus_pkg::mem_addr_t GS_BASE  = 19'h40000; // General Sound window, 256K max

	// ============================================================
	// Bank geometry
	// ============================================================
	localparam int BANK_W = 14;                              // Offset inside a 16K segment
	localparam zx_bus_pkg::mem_addr_t BANK_SIZE = 19'(1) << BANK_W;

	localparam int ROM_PAGES = 2;                            // 128K editor and 48K BASIC

	// Banks hard wired at 4000 and 8000
	localparam logic [2:0] FIXED_BANK_1 = 3'd5;
	localparam logic [2:0] FIXED_BANK_2 = 3'd2;

	// Memory read pipeline depth in clk_sys cycles
	localparam int READ_LATENCY = 2;

endpackage

//--- verilog/zx_bus_pkg.sv
// Bus types shared by the memory requesters: byte address, 7FFD page register, port index
package zx_bus_pkg;

	// Byte address into the shared memory, bit 0 picks the lane
	typedef logic [18:0] mem_addr_t;

	// 7FFD paging register, written as a byte and read back as fields
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] spare;
			logic       lock;     // Freezes paging until reset
			logic       rom_sel;
			logic       screen;   // Shadow screen, used by video only
			logic [2:0] ram_bank; // Bank seen at C000
		} f;
	} page_reg_u;

	// Requester index, also the arbiter slot
	typedef enum logic [1:0] {
		PORT_CPU = 2'd0,
		PORT_GS  = 2'd1,
		PORT_DL  = 2'd2
	} port_id_t;

endpackage
